// File: common/sketch_pkg.sv
`default_nettype none

package sketch_pkg;

        localparam int KMER_W = 98;
        localparam int TAP_W  = 80;
        localparam int ROW_W  = 64;
        localparam int CNT_W  = 2;
        localparam int SIG_W  = 32;

        // Position field sits above the taps, bits 97:90
        localparam int POS_LSB = 90;

        // Last valid position is 207, plus 4 cycles of pipeline slack
        localparam int POS_LIMIT = 212;

        typedef logic [KMER_W-1:0] kmer_t;
        typedef logic [TAP_W-1:0]  taps_t;
        typedef logic [7:0]        pos_t;
        typedef logic [ROW_W-1:0]  row_t;
        typedef logic [6:0]        row_addr_t;     // 128 rows / buckets
        typedef logic [4:0]        cnt_idx_t;      // One of 32 counters
        typedef logic [5:0]        bit_off_t;
        typedef logic [SIG_W-1:0]  sig_t;

        // Hash register reset values
        localparam row_addr_t ADDR_SEED = 7'b0101101;
        localparam cnt_idx_t  IDX_SEED1 = 5'b00101;
        localparam cnt_idx_t  IDX_SEED2 = 5'b11001;
        localparam cnt_idx_t  IDX_SEED3 = 5'b01101;
        localparam cnt_idx_t  IDX_SEED4 = 5'b01011;

        // Tap positions, MSB of the hash first
        localparam int ADDR_TAPS [7] = '{5, 20, 45, 67, 17, 72, 36};

        localparam int IDX_TAPS [4][5] = '{
                '{15, 51, 25, 50, 31},
                '{ 9, 44, 58, 13, 66},
                '{40, 24, 55, 20, 60},
                '{15, 30,  5, 61, 45}
        };

endpackage

`default_nettype wire

// File: rtl/kmer_hash.sv
`timescale 1ns/1ps
`default_nettype none

module kmer_hash (
        input  wire logic                  clk,
        input  wire logic                  reset,
        input  wire logic                  en_hash,
        input  wire sketch_pkg::taps_t     taps,
        output sketch_pkg::row_addr_t      hash_addr,
        output sketch_pkg::cnt_idx_t       hash_idx1,
        output sketch_pkg::cnt_idx_t       hash_idx2,
        output sketch_pkg::cnt_idx_t       hash_idx3,
        output sketch_pkg::cnt_idx_t       hash_idx4
);

        sketch_pkg::taps_t     mixed;
        sketch_pkg::row_addr_t next_addr;
        sketch_pkg::cnt_idx_t  next_idx [4];

        // Each tap folded with its lower neighbour
        assign mixed = taps ^ {taps[sketch_pkg::TAP_W-2:0], 1'b0};

        always_comb begin
                for (int i = 0; i < 7; i++) begin
                        next_addr[6 - i] = mixed[sketch_pkg::ADDR_TAPS[i]];
                end
        end

        always_comb begin
                for (int n = 0; n < 4; n++) begin
                        for (int i = 0; i < 5; i++) begin
                                next_idx[n][4 - i] = mixed[sketch_pkg::IDX_TAPS[n][i]];
                        end
                end
        end

        always_ff @(posedge clk or negedge reset) begin
                if (!reset) begin
                        hash_addr <= sketch_pkg::ADDR_SEED;
                        hash_idx1 <= sketch_pkg::IDX_SEED1;
                        hash_idx2 <= sketch_pkg::IDX_SEED2;
                        hash_idx3 <= sketch_pkg::IDX_SEED3;
                        hash_idx4 <= sketch_pkg::IDX_SEED4;
                end else if (en_hash) begin
                        hash_addr <= next_addr;
                        hash_idx1 <= next_idx[0];
                        hash_idx2 <= next_idx[1];
                        hash_idx3 <= next_idx[2];
                        hash_idx4 <= next_idx[3];
                end
        end

endmodule

`default_nettype wire

// File: sketch/row_capture.sv
`timescale 1ns/1ps
`default_nettype none

module row_capture (
        input  wire logic                  clk,
        input  wire logic                  reset,
        input  wire logic                  en_hash,
        input  wire logic                  read_add,
        input  wire logic                  get_row,
        input  wire sketch_pkg::pos_t      position,
        input  wire sketch_pkg::row_addr_t hash_addr,
        input  wire sketch_pkg::cnt_idx_t  hash_idx1,
        input  wire sketch_pkg::cnt_idx_t  hash_idx2,
        input  wire sketch_pkg::cnt_idx_t  hash_idx3,
        input  wire sketch_pkg::cnt_idx_t  hash_idx4,
        input  wire sketch_pkg::row_t      row_rd1,
        input  wire sketch_pkg::row_t      row_rd2,
        input  wire sketch_pkg::row_t      row_rd3,
        input  wire sketch_pkg::row_t      row_rd4,
        input  wire sketch_pkg::row_t      bucket_rd,
        output sketch_pkg::row_addr_t      row_addr,
        output sketch_pkg::row_addr_t      bucket_addr,
        output sketch_pkg::row_t           cap_row1,
        output sketch_pkg::row_t           cap_row2,
        output sketch_pkg::row_t           cap_row3,
        output sketch_pkg::row_t           cap_row4,
        output sketch_pkg::row_t           cap_bucket,
        output sketch_pkg::bit_off_t       bit_off1,
        output sketch_pkg::bit_off_t       bit_off2,
        output sketch_pkg::bit_off_t       bit_off3,
        output sketch_pkg::bit_off_t       bit_off4
);

        sketch_pkg::sig_t sig_q;

        // SRAM addresses and signature
        always_ff @(posedge clk or negedge reset) begin
                if (!reset) begin
                        row_addr    <= '0;
                        bucket_addr <= '0;
                        sig_q       <= '0;
                end else begin
                        if (en_hash || read_add) begin
                                row_addr <= hash_addr;      // Value before this edge
                        end
                        if (read_add) begin
                                bucket_addr <= position[7:1];   // Two positions per bucket
                                sig_q <= sketch_pkg::sig_t'({hash_addr, hash_idx1, hash_idx2,
                                                             hash_idx3, hash_idx4});
                        end
                end
        end

        // Read data capture
        always_ff @(posedge clk or negedge reset) begin
                if (!reset) begin
                        cap_row1 <= '0;
                        cap_row2 <= '0;
                        cap_row3 <= '0;
                        cap_row4 <= '0;
                        bit_off1 <= '0;
                        bit_off2 <= '0;
                        bit_off3 <= '0;
                        bit_off4 <= '0;
                end else if (get_row) begin
                        cap_row1 <= row_rd1;
                        cap_row2 <= row_rd2;
                        cap_row3 <= row_rd3;
                        cap_row4 <= row_rd4;
                        bit_off1 <= {hash_idx1, 1'b0};  // 2 bits per counter
                        bit_off2 <= {hash_idx2, 1'b0};
                        bit_off3 <= {hash_idx3, 1'b0};
                        bit_off4 <= {hash_idx4, 1'b0};
                end
        end

        // Signature goes into the half picked by position parity
        always_ff @(posedge clk or negedge reset) begin
                if (!reset) begin
                        cap_bucket <= '0;
                end else if (get_row) begin
                        if (!position[0]) begin
                                cap_bucket <= {sig_q, bucket_rd[sketch_pkg::SIG_W-1:0]};
                        end else begin
                                cap_bucket <= {bucket_rd[sketch_pkg::ROW_W-1 -: sketch_pkg::SIG_W],
                                               sig_q};
                        end
                end
        end

endmodule

`default_nettype wire

// File: sketch/counter_writeback.sv
`timescale 1ns/1ps
`default_nettype none

module counter_writeback (
        input  wire logic                  clk,
        input  wire logic                  reset,
        input  wire logic                  set_row,
        input  wire sketch_pkg::pos_t      position,
        input  wire sketch_pkg::row_t      cap_row1,
        input  wire sketch_pkg::row_t      cap_row2,
        input  wire sketch_pkg::row_t      cap_row3,
        input  wire sketch_pkg::row_t      cap_row4,
        input  wire sketch_pkg::row_t      cap_bucket,
        input  wire sketch_pkg::bit_off_t  bit_off1,
        input  wire sketch_pkg::bit_off_t  bit_off2,
        input  wire sketch_pkg::bit_off_t  bit_off3,
        input  wire sketch_pkg::bit_off_t  bit_off4,
        output sketch_pkg::row_t           row_wr1,
        output sketch_pkg::row_t           row_wr2,
        output sketch_pkg::row_t           row_wr3,
        output sketch_pkg::row_t           row_wr4,
        output sketch_pkg::row_t           bucket_wr
);

        logic wr_ok;

        // Saturating increment of the counter at off
        function automatic sketch_pkg::row_t bump(input sketch_pkg::row_t orig,
                                                  input sketch_pkg::bit_off_t off);
                logic [sketch_pkg::CNT_W-1:0] cnt;
                sketch_pkg::row_t             res;
                cnt = orig[off +: sketch_pkg::CNT_W];
                if (cnt != '1) begin
                        cnt = cnt + 1'b1;
                end
                res = orig;
                res[off +: sketch_pkg::CNT_W] = cnt;    // Offsets are even, never straddles
                return res;
        endfunction

        assign wr_ok = set_row && (position < sketch_pkg::POS_LIMIT);

        always_ff @(posedge clk or negedge reset) begin
                if (!reset) begin
                        row_wr1   <= '0;
                        row_wr2   <= '0;
                        row_wr3   <= '0;
                        row_wr4   <= '0;
                        bucket_wr <= '0;
                end else if (wr_ok) begin
                        row_wr1   <= bump(cap_row1, bit_off1);
                        row_wr2   <= bump(cap_row2, bit_off2);
                        row_wr3   <= bump(cap_row3, bit_off3);
                        row_wr4   <= bump(cap_row4, bit_off4);
                        bucket_wr <= cap_bucket;        // Signature already merged
                end
        end

endmodule

`default_nettype wire

// File: rtl/sketch_top.sv
`timescale 1ns/1ps
`default_nettype none

module sketch_top (
        input  wire logic                  clk,
        input  wire logic                  reset,
        input  wire logic                  en_hash,
        input  wire logic                  read_add,
        input  wire logic                  get_row,
        input  wire logic                  set_row,
        input  wire sketch_pkg::kmer_t     kmer,
        input  wire sketch_pkg::row_t      row_rd1,
        input  wire sketch_pkg::row_t      row_rd2,
        input  wire sketch_pkg::row_t      row_rd3,
        input  wire sketch_pkg::row_t      row_rd4,
        input  wire sketch_pkg::row_t      bucket_rd,
        output sketch_pkg::row_addr_t      row_addr,
        output sketch_pkg::row_addr_t      bucket_addr,
        output sketch_pkg::row_t           row_wr1,
        output sketch_pkg::row_t           row_wr2,
        output sketch_pkg::row_t           row_wr3,
        output sketch_pkg::row_t           row_wr4,
        output sketch_pkg::row_t           bucket_wr
);

        sketch_pkg::taps_t     taps;
        sketch_pkg::pos_t      position;
        sketch_pkg::row_addr_t hash_addr;
        sketch_pkg::cnt_idx_t  hash_idx1, hash_idx2, hash_idx3, hash_idx4;
        sketch_pkg::row_t      cap_row1, cap_row2, cap_row3, cap_row4;
        sketch_pkg::row_t      cap_bucket;
        sketch_pkg::bit_off_t  bit_off1, bit_off2, bit_off3, bit_off4;

        // Bits 89:80 of the record are unused
        assign taps     = kmer[sketch_pkg::TAP_W-1:0];
        assign position = kmer[sketch_pkg::KMER_W-1:sketch_pkg::POS_LSB];

        kmer_hash u_hash (
                .clk       (clk),
                .reset     (reset),
                .en_hash   (en_hash),
                .taps      (taps),
                .hash_addr (hash_addr),
                .hash_idx1 (hash_idx1),
                .hash_idx2 (hash_idx2),
                .hash_idx3 (hash_idx3),
                .hash_idx4 (hash_idx4)
        );

        row_capture u_capture (
                .clk         (clk),
                .reset       (reset),
                .en_hash     (en_hash),
                .read_add    (read_add),
                .get_row     (get_row),
                .position    (position),
                .hash_addr   (hash_addr),
                .hash_idx1   (hash_idx1),
                .hash_idx2   (hash_idx2),
                .hash_idx3   (hash_idx3),
                .hash_idx4   (hash_idx4),
                .row_rd1     (row_rd1),
                .row_rd2     (row_rd2),
                .row_rd3     (row_rd3),
                .row_rd4     (row_rd4),
                .bucket_rd   (bucket_rd),
                .row_addr    (row_addr),
                .bucket_addr (bucket_addr),
                .cap_row1    (cap_row1),
                .cap_row2    (cap_row2),
                .cap_row3    (cap_row3),
                .cap_row4    (cap_row4),
                .cap_bucket  (cap_bucket),
                .bit_off1    (bit_off1),
                .bit_off2    (bit_off2),
                .bit_off3    (bit_off3),
                .bit_off4    (bit_off4)
        );

        counter_writeback u_writeback (
                .clk        (clk),
                .reset      (reset),
                .set_row    (set_row),
                .position   (position),
                .cap_row1   (cap_row1),
                .cap_row2   (cap_row2),
                .cap_row3   (cap_row3),
                .cap_row4   (cap_row4),
                .cap_bucket (cap_bucket),
                .bit_off1   (bit_off1),
                .bit_off2   (bit_off2),
                .bit_off3   (bit_off3),
                .bit_off4   (bit_off4),
                .row_wr1    (row_wr1),
                .row_wr2    (row_wr2),
                .row_wr3    (row_wr3),
                .row_wr4    (row_wr4),
                .bucket_wr  (bucket_wr)
        );

endmodule

`default_nettype wire

// File: testbench/tb_sketch.sv
`timescale 1ns/1ps
`default_nettype none

module tb_sketch;

        localparam int CLK_PERIOD      = 10;
        // 17 sequences of 5 cycles plus reset, well under 300 cycles
        localparam int WATCHDOG_CYCLES = 1000;

        logic                  clk;
        logic                  reset;
        logic                  en_hash;
        logic                  read_add;
        logic                  get_row;
        logic                  set_row;
        sketch_pkg::kmer_t     kmer;
        sketch_pkg::row_t      row_rd1, row_rd2, row_rd3, row_rd4;
        sketch_pkg::row_t      bucket_rd;
        sketch_pkg::row_addr_t row_addr;
        sketch_pkg::row_addr_t bucket_addr;
        sketch_pkg::row_t      row_wr1, row_wr2, row_wr3, row_wr4;
        sketch_pkg::row_t      bucket_wr;

        integer seed = 32'h34f2;

        sketch_top DUT (
                .clk         (clk),
                .reset       (reset),
                .en_hash     (en_hash),
                .read_add    (read_add),
                .get_row     (get_row),
                .set_row     (set_row),
                .kmer        (kmer),
                .row_rd1     (row_rd1),
                .row_rd2     (row_rd2),
                .row_rd3     (row_rd3),
                .row_rd4     (row_rd4),
                .bucket_rd   (bucket_rd),
                .row_addr    (row_addr),
                .bucket_addr (bucket_addr),
                .row_wr1     (row_wr1),
                .row_wr2     (row_wr2),
                .row_wr3     (row_wr3),
                .row_wr4     (row_wr4),
                .bucket_wr   (bucket_wr)
        );

        initial begin
                clk = 1'b0;
                forever #(CLK_PERIOD / 2) clk = ~clk;
        end

        initial begin
                #(WATCHDOG_CYCLES * CLK_PERIOD);
                $display("Timeout after %0d cycles, tests did not finish", WATCHDOG_CYCLES);
                $display("Checks failed");
                $fatal(1, "watchdog expired");
        end

        // Hash bits {addr, idx1, idx2, idx3, idx4}, 27 bits
        function automatic logic [26:0] expected_hash(input sketch_pkg::taps_t t);
                sketch_pkg::taps_t m;
                logic [26:0]       h;
                m = t ^ (t << 1);
                h = '0;
                for (int i = 0; i < 7; i++) begin
                        h[26 - i] = m[sketch_pkg::ADDR_TAPS[i]];
                end
                for (int n = 0; n < 4; n++) begin
                        for (int i = 0; i < 5; i++) begin
                                h[19 - 5 * n - i] = m[sketch_pkg::IDX_TAPS[n][i]];
                        end
                end
                return h;
        endfunction

        function automatic sketch_pkg::cnt_idx_t index_of(input logic [26:0] h, input int n);
                return h[19 - 5 * n -: 5];
        endfunction

        function automatic sketch_pkg::row_t saturating_inc(input sketch_pkg::row_t r,
                                                            input sketch_pkg::cnt_idx_t idx);
                int               off;
                sketch_pkg::row_t field;
                sketch_pkg::row_t res;
                off   = 2 * int'(idx);
                field = (r >> off) & 64'd3;
                res   = r;
                if (field != 64'd3) begin
                        res = r + (64'd1 << off);       // No carry past a field below 3
                end
                return res;
        endfunction

        function automatic sketch_pkg::kmer_t with_position(input sketch_pkg::kmer_t k,
                                                            input sketch_pkg::pos_t p);
                sketch_pkg::kmer_t r;
                r = k;
                r[sketch_pkg::POS_LSB +: 8] = p;
                return r;
        endfunction

        task automatic compare_value(input string test, input string what,
                                     input logic [63:0] exp, input logic [63:0] act);
                assert (act === exp) else begin
                        $display("ERR %s %s expected %h actual %h", test, what, exp, act);
                        $display("Checks failed");
                        $fatal(1, "%s mismatch", test);
                end
        endtask

        task automatic random_kmer(output sketch_pkg::kmer_t k);
                logic [127:0] raw;
                raw = {$random(seed), $random(seed), $random(seed), $random(seed)};
                k   = raw[sketch_pkg::KMER_W-1:0];
        endtask

        task automatic random_row(output sketch_pkg::row_t r);
                r = {$random(seed), $random(seed)};
        endtask

        // en_hash, read_add, get_row, set_row, then sample mid-cycle
        task automatic run_sequence(input sketch_pkg::kmer_t k, input logic do_hash,
                                    input sketch_pkg::row_t r1, input sketch_pkg::row_t r2,
                                    input sketch_pkg::row_t r3, input sketch_pkg::row_t r4,
                                    input sketch_pkg::row_t b);
                @(posedge clk);
                kmer      <= k;
                row_rd1   <= r1;
                row_rd2   <= r2;
                row_rd3   <= r3;
                row_rd4   <= r4;
                bucket_rd <= b;
                en_hash   <= do_hash;
                @(posedge clk);
                en_hash  <= 1'b0;
                read_add <= 1'b1;
                @(posedge clk);
                read_add <= 1'b0;
                get_row  <= 1'b1;
                @(posedge clk);
                get_row <= 1'b0;
                set_row <= 1'b1;
                @(posedge clk);
                set_row <= 1'b0;
                @(negedge clk);
        endtask

        task automatic reset_state();
                sketch_pkg::kmer_t k;
                logic [31:0]       seed_sig;
                compare_value("reset_state", "row_addr", 64'd0, 64'(row_addr));
                compare_value("reset_state", "bucket_addr", 64'd0, 64'(bucket_addr));
                compare_value("reset_state", "row_wr1", 64'd0, row_wr1);
                compare_value("reset_state", "row_wr2", 64'd0, row_wr2);
                compare_value("reset_state", "row_wr3", 64'd0, row_wr3);
                compare_value("reset_state", "row_wr4", 64'd0, row_wr4);
                compare_value("reset_state", "bucket_wr", 64'd0, bucket_wr);
                seed_sig = 32'({sketch_pkg::ADDR_SEED, sketch_pkg::IDX_SEED1,
                                sketch_pkg::IDX_SEED2, sketch_pkg::IDX_SEED3,
                                sketch_pkg::IDX_SEED4});
                random_kmer(k);
                k = with_position(k, 8'd10);
                run_sequence(k, 1'b0, '0, '0, '0, '0, '0);      // No en_hash, seeds stay
                compare_value("reset_state", "row_addr", 64'(sketch_pkg::ADDR_SEED),
                              64'(row_addr));
                compare_value("reset_state", "signature", 64'(seed_sig), 64'(bucket_wr[63:32]));
        endtask

        task automatic hash_address();
                sketch_pkg::kmer_t k;
                logic [26:0]       h;
                for (int i = 0; i < 8; i++) begin
                        random_kmer(k);
                        h = expected_hash(k[sketch_pkg::TAP_W-1:0]);
                        run_sequence(k, 1'b1, '0, '0, '0, '0, '0);
                        compare_value("hash_address", "row_addr", 64'(h[26:20]), 64'(row_addr));
                end
        endtask

        task automatic counter_increment();
                sketch_pkg::kmer_t k;
                logic [26:0]       h;
                sketch_pkg::row_t  r [4];
                for (int i = 0; i < 4; i++) begin
                        random_kmer(k);
                        k = with_position(k, 8'($random(seed)) & 8'h7f);
                        h = expected_hash(k[sketch_pkg::TAP_W-1:0]);
                        for (int n = 0; n < 4; n++) begin
                                random_row(r[n]);
                                if (i >= 2) begin
                                        // Selected counter already at 3
                                        r[n] = r[n] | (64'd3 << (2 * int'(index_of(h, n))));
                                end
                        end
                        run_sequence(k, 1'b1, r[0], r[1], r[2], r[3], '0);
                        compare_value("counter_increment", "row_wr1",
                                      saturating_inc(r[0], index_of(h, 0)), row_wr1);
                        compare_value("counter_increment", "row_wr2",
                                      saturating_inc(r[1], index_of(h, 1)), row_wr2);
                        compare_value("counter_increment", "row_wr3",
                                      saturating_inc(r[2], index_of(h, 2)), row_wr3);
                        compare_value("counter_increment", "row_wr4",
                                      saturating_inc(r[3], index_of(h, 3)), row_wr4);
                        if (i >= 2) begin
                                compare_value("counter_increment", "saturated row_wr1", r[0],
                                              row_wr1);
                                compare_value("counter_increment", "saturated row_wr4", r[3],
                                              row_wr4);
                        end
                end
        endtask

        task automatic bucket_merge(input sketch_pkg::pos_t pos);
                sketch_pkg::kmer_t k;
                logic [26:0]       h;
                sketch_pkg::row_t  b;
                sketch_pkg::row_t  exp;
                logic [31:0]       sig;
                random_kmer(k);
                k = with_position(k, pos);
                random_row(b);
                h   = expected_hash(k[sketch_pkg::TAP_W-1:0]);
                sig = 32'(h);
                run_sequence(k, 1'b1, '0, '0, '0, '0, b);
                compare_value("bucket_merge", "bucket_addr", 64'(pos >> 1), 64'(bucket_addr));
                if (pos[0]) begin
                        exp = {b[63:32], sig};
                end else begin
                        exp = {sig, b[31:0]};
                end
                compare_value("bucket_merge", "bucket_wr", exp, bucket_wr);
        endtask

        task automatic position_gate(input sketch_pkg::pos_t pos);
                sketch_pkg::kmer_t k;
                sketch_pkg::row_t  prev [5];
                sketch_pkg::row_t  r [5];
                prev[0] = row_wr1;
                prev[1] = row_wr2;
                prev[2] = row_wr3;
                prev[3] = row_wr4;
                prev[4] = bucket_wr;
                random_kmer(k);
                k = with_position(k, pos);
                for (int n = 0; n < 5; n++) begin
                        random_row(r[n]);
                end
                run_sequence(k, 1'b1, r[0], r[1], r[2], r[3], r[4]);
                compare_value("position_gate", "row_wr1", prev[0], row_wr1);
                compare_value("position_gate", "row_wr2", prev[1], row_wr2);
                compare_value("position_gate", "row_wr3", prev[2], row_wr3);
                compare_value("position_gate", "row_wr4", prev[3], row_wr4);
                compare_value("position_gate", "bucket_wr", prev[4], bucket_wr);
        endtask

        initial begin
                reset     <= 1'b0;
                en_hash   <= 1'b0;
                read_add  <= 1'b0;
                get_row   <= 1'b0;
                set_row   <= 1'b0;
                kmer      <= '0;
                row_rd1   <= '0;
                row_rd2   <= '0;
                row_rd3   <= '0;
                row_rd4   <= '0;
                bucket_rd <= '0;
                repeat (5) @(posedge clk);
                reset <= 1'b1;
                @(negedge clk);
                reset_state();
                hash_address();
                counter_increment();
                bucket_merge(8'd100);
                bucket_merge(8'd151);
                position_gate(8'd212);
                position_gate(8'd250);
                $display("All checks passed");
                $finish;
        end

endmodule

`default_nettype wire

// File: build.f
common/sketch_pkg.sv
rtl/kmer_hash.sv
sketch/row_capture.sv
sketch/counter_writeback.sv
rtl/sketch_top.sv
testbench/tb_sketch.sv

// File: Makefile
TOP := tb_sketch

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert --top-module sketch_top -f build.f

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) \
		-f build.f -Mdir obj_dir -o V$(TOP)
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "All checks passed" sim.log

clean:
	rm -rf obj_dir sim.log
